/* common/board_regs_pkg.sv */
/*
 * Register map and bus types of the board register block.
 * Offsets are 8-bit host addresses. Anything with a nonzero high nibble
 * is outside the map. Referenced by scoped name from the RTL and the testbench.
 */
package board_regs_pkg;

    // ------------------------------------------------------------------------
    // bus data types
    // ------------------------------------------------------------------------
    typedef logic [7:0]  reg_addr_t;    // host register address
    typedef logic [31:0] reg_data_t;    // host register data word

    // ------------------------------------------------------------------------
    // register offsets
    // ------------------------------------------------------------------------
    localparam reg_addr_t REG_STATUS    = 8'd0;   // board status / axis enables
    localparam reg_addr_t REG_TIMEOUT   = 8'd3;   // watchdog period, in ticks
    localparam reg_addr_t REG_VERSION   = 8'd4;   // hardware version word
    localparam reg_addr_t REG_TEMPSNS   = 8'd5;   // temperature sensor
    localparam reg_addr_t REG_DIGIOUT   = 8'd6;   // digital outputs, masked write
    localparam reg_addr_t REG_FWVERSION = 8'd7;   // firmware version
    localparam reg_addr_t REG_DIGIN     = 8'd10;  // limit, home and fault inputs
    localparam reg_addr_t REG_SAFETY    = 8'd11;  // safety chain disable mask
    localparam reg_addr_t REG_WDOG      = 8'd12;  // watchdog disable mask
    localparam reg_addr_t REG_DISABLE   = 8'd13;  // sticky disable register

    // ------------------------------------------------------------------------
    // identification
    // ------------------------------------------------------------------------
    // board type tag in ascii, "MC4A"
    localparam reg_data_t BOARD_VERSION = 32'h4D43_3441;
    localparam reg_data_t FW_VERSION    = 32'h0000_0003;  // firmware rev

    // axis count, top nibble of the status word
    localparam logic [3:0] NUM_AXES = 4'd4;

endpackage

/* common/safety_pkg.sv */
/*
 * Types shared by the safety datapaths: the per-axis disable mask and
 * the tick counts of the watchdog and the motor voltage settle timer.
 */
package safety_pkg;

    // one bit per axis, 1 means amplifier disabled
    typedef logic [3:0] axis_mask_t;

    // watchdog period in ticks, 0 turns the watchdog off
    typedef logic [15:0] wdog_period_t;

    // settle length in ticks
    typedef logic [15:0] settle_count_t;

endpackage

/* hdl/board_ctrl_top.sv */
/*
 * Board register block of the four-axis motor controller. Connects the
 * register file to the tick prescaler, watchdog, settle timer and
 * amplifier disable logic. TICK_DIV and MV_SETTLE_TICKS set the timing.
 */
`timescale 1ns/1ps

module board_ctrl_top #(
    parameter int                        TICK_DIV        = 256,
    parameter safety_pkg::settle_count_t MV_SETTLE_TICKS = 16'd7680
) (
    input  logic                      sysclk,
    input  logic                      reset,          // sync, active low
    input  board_regs_pkg::reg_addr_t reg_addr,
    input  board_regs_pkg::reg_data_t reg_wdata,
    input  logic                      reg_wen,
    output board_regs_pkg::reg_data_t reg_rdata,
    input  safety_pkg::axis_mask_t    neg_limit,
    input  safety_pkg::axis_mask_t    pos_limit,
    input  safety_pkg::axis_mask_t    home,
    input  safety_pkg::axis_mask_t    fault,
    input  safety_pkg::axis_mask_t    safety_amp_disable,
    input  logic                      relay,
    input  logic                      mv_good,
    input  logic                      v_fault,
    input  logic [3:0]                board_id,
    input  logic [15:0]               temp_sense,
    output safety_pkg::axis_mask_t    amp_disable,
    output safety_pkg::axis_mask_t    dout,
    output logic                      pwr_enable,
    output logic                      relay_on
);

    logic                     tick;             // slow time base
    logic                     host_write;
    logic                     status_wen;
    logic                     wdog_timeout;
    safety_pkg::axis_mask_t   axis_en_bits;
    safety_pkg::axis_mask_t   axis_en_mask;
    safety_pkg::axis_mask_t   reg_disable;      // sticky disable state
    safety_pkg::axis_mask_t   wdog_amp_disable;
    safety_pkg::axis_mask_t   mv_amp_disable;
    safety_pkg::wdog_period_t wdog_period;

    board_regs u_board_regs (
        .sysclk, .reset,
        .reg_addr, .reg_wdata, .reg_wen, .reg_rdata,
        .neg_limit, .pos_limit, .home, .fault, .safety_amp_disable,
        .relay, .mv_good, .v_fault, .board_id, .temp_sense,
        .reg_disable, .wdog_amp_disable, .wdog_timeout,
        .host_write, .status_wen, .axis_en_bits, .axis_en_mask,
        .wdog_period, .pwr_enable, .relay_on, .dout
    );

    tick_prescaler #(.TICK_DIV(TICK_DIV)) u_tick_prescaler (
        .sysclk, .reset, .tick
    );

    wdog_timer u_wdog_timer (
        .sysclk, .reset, .tick, .host_write, .wdog_period,
        .wdog_timeout, .wdog_amp_disable
    );

    mv_settle_timer #(.MV_SETTLE_TICKS(MV_SETTLE_TICKS)) u_mv_settle_timer (
        .sysclk, .reset, .tick, .mv_good, .mv_amp_disable
    );

    amp_disable_ctrl u_amp_disable_ctrl (
        .sysclk, .reset, .status_wen, .axis_en_bits, .axis_en_mask,
        .pwr_enable, .wdog_amp_disable, .mv_amp_disable, .safety_amp_disable,
        .reg_disable, .amp_disable
    );

endmodule

/* hdl/board_regs.sv */
/*
 * Board register file. Decodes host writes into the board controls
 * (relay, motor power, digital outputs, watchdog period), hands axis
 * enable requests to the disable block, and serves registered reads
 * one cycle after the address.
 */
`timescale 1ns/1ps

module board_regs (
    input  logic                      sysclk,
    input  logic                      reset,              // sync, active low

    // host bus
    input  board_regs_pkg::reg_addr_t reg_addr,
    input  board_regs_pkg::reg_data_t reg_wdata,
    input  logic                      reg_wen,
    output board_regs_pkg::reg_data_t reg_rdata,

    // board inputs
    input  safety_pkg::axis_mask_t    neg_limit,
    input  safety_pkg::axis_mask_t    pos_limit,
    input  safety_pkg::axis_mask_t    home,
    input  safety_pkg::axis_mask_t    fault,
    input  safety_pkg::axis_mask_t    safety_amp_disable,
    input  logic                      relay,              // relay contact state
    input  logic                      mv_good,            // motor voltage good
    input  logic                      v_fault,
    input  logic [3:0]                board_id,           // rotary switch
    input  logic [15:0]               temp_sense,

    // from the safety datapaths
    input  safety_pkg::axis_mask_t    reg_disable,
    input  safety_pkg::axis_mask_t    wdog_amp_disable,
    input  logic                      wdog_timeout,

    // to the safety datapaths
    output logic                      host_write,         // any bus write
    output logic                      status_wen,         // write to REG_STATUS
    output safety_pkg::axis_mask_t    axis_en_bits,
    output safety_pkg::axis_mask_t    axis_en_mask,
    output safety_pkg::wdog_period_t  wdog_period,

    // board controls
    output logic                      pwr_enable,
    output logic                      relay_on,
    output safety_pkg::axis_mask_t    dout
);

    board_regs_pkg::reg_data_t rd_mux;    // read word before the output flop

    // ------------------------------------------------------------------------
    // write strobes
    // ------------------------------------------------------------------------
    assign host_write   = reg_wen;        // any write kicks the watchdog
    assign status_wen   = reg_wen && (reg_addr == board_regs_pkg::REG_STATUS);
    assign axis_en_bits = reg_wdata[3:0];  // enable value per axis
    assign axis_en_mask = reg_wdata[11:8]; // which axes to touch

    // control registers, masked updates
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            pwr_enable  <= 1'b0;           // motor power off
            relay_on    <= 1'b0;           // safety relay open
            dout        <= '0;
            wdog_period <= '0;             // watchdog off
        end else if (reg_wen) begin
            case (reg_addr)
                board_regs_pkg::REG_STATUS: begin
                    if (reg_wdata[17])
                        relay_on <= reg_wdata[16];
                    if (reg_wdata[19])
                        pwr_enable <= reg_wdata[18];
                end
                board_regs_pkg::REG_TIMEOUT: wdog_period <= reg_wdata[15:0];
                board_regs_pkg::REG_DIGIOUT: begin
                    // bits 11:8 select, bits 3:0 give the level
                    for (int i = 0; i < 4; i++) begin
                        if (reg_wdata[8 + i])
                            dout[i] <= reg_wdata[i];
                    end
                end
                default: ;                 // read-only or unmapped
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // read mux
    // ------------------------------------------------------------------------
    always_comb begin
        case (reg_addr)
            board_regs_pkg::REG_STATUS:    rd_mux = {
                board_regs_pkg::NUM_AXES, board_id,            // byte 3
                wdog_timeout, 3'd0,                            // byte 2
                mv_good, pwr_enable, ~relay, relay_on,
                4'd0, fault,                                   // byte 1
                safety_amp_disable, ~reg_disable};             // byte 0, 1 = enabled
            board_regs_pkg::REG_TIMEOUT:   rd_mux = {16'd0, wdog_period};
            board_regs_pkg::REG_VERSION:   rd_mux = board_regs_pkg::BOARD_VERSION;
            board_regs_pkg::REG_TEMPSNS:   rd_mux = {16'd0, temp_sense};
            board_regs_pkg::REG_DIGIOUT:   rd_mux = {28'd0, dout};
            board_regs_pkg::REG_FWVERSION: rd_mux = board_regs_pkg::FW_VERSION;
            board_regs_pkg::REG_DIGIN:     rd_mux = {15'd0, v_fault, dout,
                                                     neg_limit, pos_limit, home};
            board_regs_pkg::REG_SAFETY:    rd_mux = {28'd0, safety_amp_disable};
            board_regs_pkg::REG_WDOG:      rd_mux = {28'd0, wdog_amp_disable};
            board_regs_pkg::REG_DISABLE:   rd_mux = {28'd0, reg_disable};
            default:                       rd_mux = '0;   // unmapped
        endcase
    end

    // read data registered, held during writes
    always_ff @(posedge sysclk) begin
        if (!reset)
            reg_rdata <= '0;
        else if (!reg_wen)
            reg_rdata <= rd_mux;
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# compile the board register block with Verilator and run the testbench
cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module board_ctrl_tb -f src.f \
    -Mdir obj_dir -o board_ctrl_sim || { echo "build failed"; exit 1; }

sim_out=$(./obj_dir/board_ctrl_sim 2>&1)
echo "$sim_out"

echo "$sim_out" | grep -qF '*** TEST PASSED ***' \
    && echo "run ok" \
    || { echo "run failed"; exit 1; }

/* safety/amp_disable_ctrl.sv */
/*
 * Per-axis amplifier disable. Holds the sticky disable register fed by
 * host enable requests, the watchdog and the external safety chain,
 * and merges it with the settle timer hold into amp_disable.
 */
`timescale 1ns/1ps

module amp_disable_ctrl (
    input  logic                   sysclk,
    input  logic                   reset,              // sync, active low
    input  logic                   status_wen,         // host wrote REG_STATUS
    input  safety_pkg::axis_mask_t axis_en_bits,       // 1 = enable axis
    input  safety_pkg::axis_mask_t axis_en_mask,       // 1 = apply bit
    input  logic                   pwr_enable,
    input  safety_pkg::axis_mask_t wdog_amp_disable,
    input  safety_pkg::axis_mask_t mv_amp_disable,
    input  safety_pkg::axis_mask_t safety_amp_disable,
    output safety_pkg::axis_mask_t reg_disable,
    output safety_pkg::axis_mask_t amp_disable
);

    safety_pkg::axis_mask_t req_disable;   // register after a masked host update

    // masked axes take the inverse enable, others keep their state
    assign req_disable = (reg_disable & ~axis_en_mask) | (~axis_en_bits & axis_en_mask);

    // ------------------------------------------------------------------------
    // sticky disable register
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            reg_disable <= '1;                          // all axes off
        end else if (status_wen) begin
            // no enables while motor power is off
            reg_disable <= pwr_enable ? req_disable : '1;
        end else begin
            // faults only ever add disables
            reg_disable <= reg_disable | wdog_amp_disable | safety_amp_disable;
        end
    end

    // settle hold on top of the sticky state
    assign amp_disable = reg_disable | mv_amp_disable;

endmodule

/* safety/mv_settle_timer.sv */
/*
 * Motor voltage settle timer. Keeps every amplifier disabled until
 * mv_good has stayed high for MV_SETTLE_TICKS ticks in a row; a drop
 * of mv_good restarts the wait.
 */
`timescale 1ns/1ps

module mv_settle_timer #(
    parameter safety_pkg::settle_count_t MV_SETTLE_TICKS = 16'd7680
) (
    input  logic                   sysclk,
    input  logic                   reset,          // sync, active low
    input  logic                   tick,
    input  logic                   mv_good,        // motor voltage good
    output safety_pkg::axis_mask_t mv_amp_disable
);

    safety_pkg::settle_count_t settle_cnt;        // ticks of good voltage

    always_ff @(posedge sysclk) begin
        if (!reset) begin
            settle_cnt     <= '0;
            mv_amp_disable <= '1;                 // hold from power up
        end else if (!mv_good) begin
            settle_cnt     <= '0;                 // voltage lost, restart
            mv_amp_disable <= '1;
        end else if (settle_cnt == MV_SETTLE_TICKS) begin
            mv_amp_disable <= '0;                 // settled, release
        end else begin
            mv_amp_disable <= '1;
            if (tick)
                settle_cnt <= settle_cnt + 1'b1;
        end
    end

endmodule

/* safety/tick_prescaler.sv */
/*
 * Slow time base for the safety timers. Emits a one-cycle tick
 * every TICK_DIV sysclk cycles.
 */
`timescale 1ns/1ps

module tick_prescaler #(
    parameter int TICK_DIV = 256                  // sysclk cycles per tick
) (
    input  logic sysclk,
    input  logic reset,                           // sync, active low
    output logic tick
);

    localparam int CW = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam logic [CW-1:0] LAST = CW'(TICK_DIV - 1);

    logic [CW-1:0] div_cnt;

    always_ff @(posedge sysclk) begin
        if (!reset) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else if (div_cnt == LAST) begin
            div_cnt <= '0;                        // wrap
            tick    <= 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            tick    <= 1'b0;
        end
    end

endmodule

/* safety/wdog_timer.sv */
/*
 * Host watchdog. Counts ticks since the last host write; once the count
 * has reached the programmed period, the next tick raises the timeout
 * and disables every axis. Any host write clears both. Period 0 = off.
 */
`timescale 1ns/1ps

module wdog_timer (
    input  logic                     sysclk,
    input  logic                     reset,             // sync, active low
    input  logic                     tick,              // prescaler strobe
    input  logic                     host_write,        // any bus write
    input  safety_pkg::wdog_period_t wdog_period,
    output logic                     wdog_timeout,
    output safety_pkg::axis_mask_t   wdog_amp_disable
);

    safety_pkg::wdog_period_t wdog_count;   // ticks since last write

    // ------------------------------------------------------------------------
    // count and flag
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            wdog_count       <= '0;
            wdog_timeout     <= 1'b0;
            wdog_amp_disable <= '0;
        end else if (host_write) begin
            // host alive, start over
            wdog_count       <= '0;
            wdog_timeout     <= 1'b0;
            wdog_amp_disable <= '0;
        end else if (tick && (wdog_period != '0)) begin
            if (wdog_count < wdog_period) begin
                wdog_count <= wdog_count + 1'b1;
            end else begin
                // period used up, one more tick
                wdog_timeout     <= 1'b1;
                wdog_amp_disable <= '1;          // all axes off
            end
        end
    end

endmodule

/* src.f */
common/board_regs_pkg.sv
common/safety_pkg.sv
safety/tick_prescaler.sv
safety/wdog_timer.sv
safety/mv_settle_timer.sv
safety/amp_disable_ctrl.sv
hdl/board_regs.sv
hdl/board_ctrl_top.sv
testbench/tb_clock_gen.sv
testbench/board_ctrl_tb.sv

/* testbench/board_ctrl_tb.sv */
/*
 * Directed testbench for the board register block. Keeps its own model of
 * the control registers and the sticky disable state, drives the bus
 * 1 ns after the rising edge and stops at the first mismatch.
 */
`timescale 1ns/1ps

module board_ctrl_tb;

    localparam int TICK_DIV     = 4;
    localparam int SETTLE_TICKS = 10;
    localparam int DRIVE_DLY    = 1;    // ns after the rising edge

    logic                      sysclk;
    logic                      reset;
    board_regs_pkg::reg_addr_t reg_addr;
    board_regs_pkg::reg_data_t reg_wdata;
    board_regs_pkg::reg_data_t reg_rdata;
    logic                      reg_wen;
    safety_pkg::axis_mask_t    neg_limit, pos_limit, home, fault;
    safety_pkg::axis_mask_t    safety_amp_disable;
    logic                      relay, mv_good, v_fault;
    logic [3:0]                board_id;
    logic [15:0]               temp_sense;
    safety_pkg::axis_mask_t    amp_disable, dout;
    logic                      pwr_enable, relay_on;

    // reference model
    safety_pkg::axis_mask_t    exp_dout;
    safety_pkg::axis_mask_t    exp_disable;    // sticky disable, 1 means off
    logic                      exp_pwr, exp_relay;

    tb_clock_gen u_clk (.sysclk);

    board_ctrl_top #(
        .TICK_DIV(TICK_DIV),
        .MV_SETTLE_TICKS(safety_pkg::settle_count_t'(SETTLE_TICKS))
    ) DUT (
        .sysclk, .reset, .reg_addr, .reg_wdata, .reg_wen, .reg_rdata,
        .neg_limit, .pos_limit, .home, .fault, .safety_amp_disable,
        .relay, .mv_good, .v_fault, .board_id, .temp_sense,
        .amp_disable, .dout, .pwr_enable, .relay_on
    );

    // ------------------------------------------------------------------------
    // reporting and compares
    // ------------------------------------------------------------------------
    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_data(input string name, input board_regs_pkg::reg_data_t exp,
                              input board_regs_pkg::reg_data_t act);
        if (act !== exp)
            stop_on_error($sformatf("mismatch in %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_mask(input string name, input safety_pkg::axis_mask_t exp,
                              input safety_pkg::axis_mask_t act);
        if (act !== exp)
            stop_on_error($sformatf("mismatch in %s: expected %b, actual %b", name, exp, act));
    endtask

    // ------------------------------------------------------------------------
    // bus helpers
    // ------------------------------------------------------------------------
    task automatic next_cycle();
        @(posedge sysclk);
        #DRIVE_DLY;
    endtask

    task automatic bus_write(input board_regs_pkg::reg_addr_t addr,
                             input board_regs_pkg::reg_data_t data);
        next_cycle();
        reg_addr  = addr;
        reg_wdata = data;
        reg_wen   = 1'b1;
        next_cycle();           // write taken at this edge
        reg_wen   = 1'b0;
    endtask

    task automatic bus_read(input board_regs_pkg::reg_addr_t addr,
                            output board_regs_pkg::reg_data_t data);
        next_cycle();
        reg_addr = addr;
        next_cycle();           // one cycle read latency
        data     = reg_rdata;
    endtask

    task automatic read_check(input string name, input board_regs_pkg::reg_addr_t addr,
                              input board_regs_pkg::reg_data_t exp);
        board_regs_pkg::reg_data_t rd;
        bus_read(addr, rd);
        check_data(name, exp, rd);
    endtask

    // status write and the matching model update
    task automatic status_write(input board_regs_pkg::reg_data_t data);
        bus_write(board_regs_pkg::REG_STATUS, data);
        // the power state before the write edge decides
        for (int i = 0; i < 4; i++) begin
            if (!exp_pwr)
                exp_disable[i] = 1'b1;          // no enables while unpowered
            else if (data[8 + i])
                exp_disable[i] = ~data[i];      // enable bit 1 clears the disable
        end
        if (data[17])
            exp_relay = data[16];
        if (data[19])
            exp_pwr = data[18];
    endtask

    // expected status word from the current inputs and model
    function automatic board_regs_pkg::reg_data_t status_word(input logic wdog_flag);
        board_regs_pkg::reg_data_t w;
        w[31:28] = board_regs_pkg::NUM_AXES;
        w[27:24] = board_id;
        w[23]    = wdog_flag;
        w[22:20] = 3'b000;
        w[19]    = mv_good;
        w[18]    = exp_pwr;
        w[17]    = ~relay;
        w[16]    = exp_relay;
        w[15:12] = 4'b0000;
        w[11:8]  = fault;
        w[7:4]   = safety_amp_disable;
        w[3:0]   = ~exp_disable;        // 1 = axis enabled
        return w;
    endfunction

    // ------------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------------
    task automatic reset_defaults();
        check_data("reset rdata", '0, reg_rdata);
        check_mask("reset amp_disable", 4'hF, amp_disable);
        check_mask("reset dout", 4'h0, dout);
        check_mask("reset pwr/relay", 4'h0, {2'b00, pwr_enable, relay_on});
        read_check("reset status", board_regs_pkg::REG_STATUS, status_word(1'b0));
        read_check("version", board_regs_pkg::REG_VERSION, board_regs_pkg::BOARD_VERSION);
        read_check("fw version", board_regs_pkg::REG_FWVERSION, board_regs_pkg::FW_VERSION);
    endtask

    task automatic readback_regs();
        safety_pkg::axis_mask_t sel;
        safety_pkg::axis_mask_t lvl;
        read_check("tempsns", board_regs_pkg::REG_TEMPSNS, {16'd0, temp_sense});
        for (int i = 0; i < 4; i++) begin
            sel = 4'($urandom);
            lvl = 4'($urandom);
            bus_write(board_regs_pkg::REG_DIGIOUT, {20'd0, sel, 4'd0, lvl});
            exp_dout = (exp_dout & ~sel) | (lvl & sel);  // only selected bits move
            check_mask("dout pins", exp_dout, dout);
            read_check("digiout", board_regs_pkg::REG_DIGIOUT, {28'd0, exp_dout});
        end
        read_check("digin", board_regs_pkg::REG_DIGIN,
                   {15'd0, v_fault, exp_dout, neg_limit, pos_limit, home});
        read_check("unmapped 0x21", 8'h21, '0);
        read_check("unmapped 0x01", 8'h01, '0);
    endtask

    task automatic power_and_settle();
        int cycles;
        status_write(32'h000F_0000);    // power and relay on with an empty axis mask
        check_mask("power on", 4'b0011, {2'b00, pwr_enable, relay_on});
        next_cycle();
        mv_good = 1'b1;                 // motor voltage comes up
        relay   = 1'b1;                 // contact follows relay_on
        status_write(32'h0000_0F0B);    // enable axes 0, 1, 3
        cycles = 2;                     // edges spent by the write
        while (amp_disable == 4'hF) begin
            if (cycles >= (SETTLE_TICKS + 1) * TICK_DIV)
                stop_on_error("settle hold never released amp_disable");
            next_cycle();
            cycles++;
        end
        if (cycles < (SETTLE_TICKS - 1) * TICK_DIV)
            stop_on_error($sformatf("settle hold released after only %0d cycles", cycles));
        check_mask("settle release", exp_disable, amp_disable);
        read_check("status powered", board_regs_pkg::REG_STATUS, status_word(1'b0));
    endtask

    task automatic watchdog_trip();
        board_regs_pkg::reg_data_t rd;
        int tries;
        bus_write(board_regs_pkg::REG_TIMEOUT, 32'd3);
        rd    = '0;
        tries = 0;
        while (rd[23] == 1'b0) begin    // poll the timeout flag with reads only
            if (tries >= 12)
                stop_on_error("watchdog timeout flag never rose");
            bus_read(board_regs_pkg::REG_STATUS, rd);
            tries++;
        end
        if (tries * 2 < 3 * TICK_DIV)
            stop_on_error("watchdog timeout rose before the period ran out");
        exp_disable = 4'hF;             // watchdog mask is sticky
        read_check("status timeout", board_regs_pkg::REG_STATUS, status_word(1'b1));
        read_check("wdog mask", board_regs_pkg::REG_WDOG, 32'h0000_000F);
        read_check("wdog period", board_regs_pkg::REG_TIMEOUT, 32'd3);
        check_mask("wdog amp_disable", 4'hF, amp_disable);
        bus_write(board_regs_pkg::REG_TIMEOUT, 32'd0);   // clears the flag and stops the watchdog
        read_check("wdog cleared", board_regs_pkg::REG_WDOG, '0);
        read_check("status after clear", board_regs_pkg::REG_STATUS, status_word(1'b0));
        check_mask("sticky after clear", 4'hF, amp_disable);
        status_write(32'h0000_0F0F);    // re-enable every axis
        check_mask("re-enable", exp_disable, amp_disable);
    endtask

    task automatic safety_chain();
        safety_pkg::axis_mask_t hit;
        hit = 4'($urandom_range(1, 15));
        next_cycle();
        safety_amp_disable = hit;
        exp_disable = exp_disable | hit;
        read_check("safety mask", board_regs_pkg::REG_SAFETY, {28'd0, hit});
        safety_amp_disable = '0;        // chain closes again
        read_check("safety sticky", board_regs_pkg::REG_DISABLE, {28'd0, exp_disable});
        check_mask("safety amp_disable", exp_disable, amp_disable);
    endtask

    task automatic power_off_lock();
        status_write(32'h0008_0000);    // power off with the relay left alone
        check_mask("power off", 4'b0001, {2'b00, pwr_enable, relay_on});
        status_write(32'h0000_0F0F);    // try to enable while unpowered
        check_mask("unpowered enable", 4'hF, amp_disable);
        read_check("unpowered disable", board_regs_pkg::REG_DISABLE, {28'd0, exp_disable});
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        void'($urandom(27));
        reset      = 1'b0;
        reg_addr   = '0;
        reg_wdata  = '0;
        reg_wen    = 1'b0;
        neg_limit  = 4'($urandom);
        pos_limit  = 4'($urandom);
        home       = 4'($urandom);
        fault      = 4'($urandom);
        board_id   = 4'($urandom);
        temp_sense = 16'($urandom);
        v_fault    = 1'($urandom);
        safety_amp_disable = '0;
        relay      = 1'b0;
        mv_good    = 1'b0;
        exp_dout    = '0;
        exp_disable = 4'hF;
        exp_pwr     = 1'b0;
        exp_relay   = 1'b0;
        repeat (8) @(posedge sysclk);
        #DRIVE_DLY;
        reset = 1'b1;

        reset_defaults();
        readback_regs();
        power_and_settle();
        watchdog_trip();
        safety_chain();
        power_off_lock();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* testbench/tb_clock_gen.sv */
/*
 * Free running sysclk for the board register testbench.
 * Period 4 ns, starts low.
 */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real HALF_PERIOD = 2.0    // ns
) (
    output logic sysclk
);

    initial begin
        sysclk = 1'b0;
        forever #(HALF_PERIOD) sysclk = ~sysclk;
    end

endmodule
